/* logic/elevator_pkg.sv */
/*
 * Shared types for the elevator floor-request controller.
 * Every RTL block imports this package for floor numbers, the car
 * status, the dispatch payload and the state encodings.
 */

`default_nettype none

package elevator_pkg;

    ////////////////////
    // Floor numbering

    // Four bits cover up to 16 floors
    localparam int FLOOR_W = 4;

    // Floor index, 0 is the lowest floor
    typedef logic [FLOOR_W-1:0] floor_t;

    ////////////////////
    // Car and dispatch payloads

    // Status reported by the car motion FSM
    typedef struct packed {
        floor_t floor;
        logic   stopped;   // Car stands at a floor
    } car_status_t;

    // Target offered to the car
    typedef struct packed {
        floor_t target;
        logic   up;        // Target lies above the car
    } dispatch_t;

    ////////////////////
    // State encodings

    typedef enum logic [1:0] {
        MODE_OFF,
        MODE_EMERGENCY,
        MODE_NORMAL
    } mode_t;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_OFFER,
        DISP_TRAVEL
    } disp_state_t;

endpackage

`default_nettype wire

/* logic/service_mode.sv */
/*
 * Operating mode register and door permission gating.
 * The mode follows power and emergency one cycle late and steers
 * the request latch, the stack and the dispatcher.
 */

`timescale 1ns/1ps
`default_nettype none

module service_mode
    import elevator_pkg::*;
(
    input  wire   clock,
    input  wire   reset_n,
    input  wire   power_on,
    input  wire   emergency,
    input  wire   door_open_button,
    input  wire   door_close_button,
    input  wire   car_stopped,
    output mode_t mode,
    output logic  door_open_allowed,
    output logic  door_close_allowed
);

    mode_t mode_next;

    ////////////////////
    // Mode selection

    // Power-off wins over emergency
    always_comb begin
        if (!power_on) begin
            mode_next = MODE_OFF;
        end else if (emergency) begin
            mode_next = MODE_EMERGENCY;
        end else begin
            mode_next = MODE_NORMAL;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mode <= MODE_OFF;
        end else begin
            mode <= mode_next;
        end
    end

    ////////////////////
    // Door gating

    // Doors only while the car stands and power is up
    always_comb begin
        door_open_allowed  = door_open_button && car_stopped && (mode != MODE_OFF);
        door_close_allowed = door_close_button && car_stopped && (mode != MODE_OFF);
    end

endmodule

`default_nettype wire

/* logic/request_latch.sv */
/*
 * Hall call and car panel request capture.
 * Keeps both light masks and a mask of floors waiting to be pushed,
 * feeds the request stack one floor per cycle and clears served floors.
 */

`timescale 1ns/1ps
`default_nettype none

module request_latch
    import elevator_pkg::*;
#(
    parameter int NUM_FLOORS = 11
) (
    input  wire                    clock,
    input  wire                    reset_n,
    input  mode_t                  mode,
    input  wire   [NUM_FLOORS-1:0] call_buttons,
    input  wire   [NUM_FLOORS-1:0] panel_buttons,
    input  car_status_t            car_status,
    input  wire                    served_valid,
    input  floor_t                 served_floor,
    output logic                   push_valid,
    output floor_t                 push_floor,
    input  wire                    push_ready,
    output logic  [NUM_FLOORS-1:0] call_lights,
    output logic  [NUM_FLOORS-1:0] panel_lights
);

    logic [NUM_FLOORS-1:0] queued;
    logic [NUM_FLOORS-1:0] here_mask;
    logic [NUM_FLOORS-1:0] served_mask;
    logic [NUM_FLOORS-1:0] pushed_mask;
    logic [NUM_FLOORS-1:0] call_accept;
    logic [NUM_FLOORS-1:0] panel_accept;
    logic [NUM_FLOORS-1:0] new_requests;
    logic                  normal;

    assign normal = (mode == MODE_NORMAL);

    ////////////////////
    // Press acceptance

    always_comb begin
        for (int i = 0; i < NUM_FLOORS; i++) begin
            here_mask[i]   = car_status.stopped && (car_status.floor == floor_t'(i));
            served_mask[i] = served_valid && (served_floor == floor_t'(i));
            pushed_mask[i] = push_valid && push_ready && (push_floor == floor_t'(i));
        end
    end

    // No new request for the floor the car stands at
    assign call_accept  = call_buttons & ~call_lights & ~here_mask & {NUM_FLOORS{normal}};
    assign panel_accept = panel_buttons & ~panel_lights & ~here_mask & {NUM_FLOORS{normal}};

    // Only floors not already pending get queued
    assign new_requests = (call_accept | panel_accept) & ~(call_lights | panel_lights);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            queued       <= '0;
        end else if (!normal) begin
            call_lights  <= '0;
            panel_lights <= '0;
            queued       <= '0;
        end else begin
            call_lights  <= (call_lights | call_accept) & ~served_mask;
            panel_lights <= (panel_lights | panel_accept) & ~served_mask;
            queued       <= (queued | new_requests) & ~pushed_mask;
        end
    end

    ////////////////////
    // Push side

    // Lowest queued floor goes first
    always_comb begin
        push_floor = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (queued[i]) begin
                push_floor = floor_t'(i);
            end
        end
    end

    assign push_valid = |queued;

    // The dispatcher only serves floors that are still lit
    assert property (@(posedge clock) disable iff (!reset_n)
        served_valid |-> (call_lights[served_floor] || panel_lights[served_floor]))
        else $error("served floor %0d has no light on", served_floor);

endmodule

`default_nettype wire

/* logic/request_stack.sv */
/*
 * Last-in-first-out store of requested floors.
 * Pushes come from the request latch, pops go to the dispatcher.
 * A simultaneous push and pop replaces the top entry.
 */

`timescale 1ns/1ps
`default_nettype none

module request_stack
    import elevator_pkg::*;
#(
    parameter int NUM_FLOORS = 11
) (
    input  wire    clock,
    input  wire    reset_n,
    input  mode_t  mode,
    input  wire    push_valid,
    input  floor_t push_floor,
    output logic   push_ready,
    output logic   top_valid,
    output floor_t top_floor,
    input  wire    top_ready
);

    localparam int PTR_W = $clog2(NUM_FLOORS + 1);

    floor_t           mem [NUM_FLOORS];
    logic [PTR_W-1:0] sp;
    logic [PTR_W-1:0] top_idx;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full       = (sp == PTR_W'(NUM_FLOORS));
    assign push_ready = !full;
    assign top_valid  = (sp != '0);

    // Guard the index when the stack is empty
    assign top_idx   = top_valid ? (sp - 1'b1) : '0;
    assign top_floor = mem[top_idx];

    assign do_push = (mode == MODE_NORMAL) && push_valid && push_ready;
    assign do_pop  = (mode == MODE_NORMAL) && top_valid && top_ready;

    ////////////////////
    // Stack pointer

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sp <= '0;
        end else if (mode != MODE_NORMAL) begin
            sp <= '0;
        end else if (do_push && !do_pop) begin
            sp <= sp + 1'b1;
        end else if (do_pop && !do_push) begin
            sp <= sp - 1'b1;
        end
    end

    ////////////////////
    // Storage

    // Push with pop overwrites the old top in place
    always_ff @(posedge clock) begin
        if (do_push && do_pop) begin
            mem[top_idx] <= push_floor;
        end else if (do_push) begin
            mem[sp] <= push_floor;
        end
    end

    // A full stack only keeps its size or shrinks by the pop
    assert property (@(posedge clock) disable iff (!reset_n)
        (full && mode == MODE_NORMAL)
            |=> (sp == PTR_W'(NUM_FLOORS) - PTR_W'($past(top_ready))))
        else $error("push accepted into a full request stack");

endmodule

`default_nettype wire

/* logic/car_dispatcher.sv */
/*
 * Dispatch FSM between the request stack and the car.
 * Pops a target, offers it with a direction over a valid/ready
 * handshake, follows the trip and reports the served floor.
 */

`timescale 1ns/1ps
`default_nettype none

module car_dispatcher
    import elevator_pkg::*;
(
    input  wire         clock,
    input  wire         reset_n,
    input  mode_t       mode,
    input  wire         top_valid,
    input  floor_t      top_floor,
    output logic        top_ready,
    input  car_status_t car_status,
    output logic        dispatch_valid,
    output dispatch_t   dispatch,
    input  wire         dispatch_ready,
    output logic        served_valid,
    output floor_t      served_floor
);

    disp_state_t state;
    dispatch_t   offer;
    logic        normal;
    logic        pop_here;
    logic        arrived;

    assign normal = (mode == MODE_NORMAL);

    // Popped floor is where the car already stands
    assign pop_here = top_valid && car_status.stopped && (top_floor == car_status.floor);
    assign arrived  = car_status.stopped && (car_status.floor == offer.target);

    ////////////////////
    // Handshake outputs

    assign top_ready      = normal && (state == DISP_IDLE);
    assign dispatch_valid = normal && (state == DISP_OFFER);
    assign dispatch       = offer;

    always_comb begin
        served_valid = 1'b0;
        served_floor = top_floor;
        if (normal && state == DISP_IDLE && pop_here) begin
            served_valid = 1'b1;
        end else if (normal && state == DISP_TRAVEL && arrived) begin
            served_valid = 1'b1;
            served_floor = offer.target;
        end
    end

    ////////////////////
    // State machine

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= DISP_IDLE;
        end else if (!normal) begin
            state <= DISP_IDLE;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (top_valid && !pop_here) begin
                        state <= DISP_OFFER;
                    end
                end
                DISP_OFFER: begin
                    if (dispatch_ready) begin
                        state <= DISP_TRAVEL;
                    end
                end
                DISP_TRAVEL: begin
                    if (arrived) begin
                        state <= DISP_IDLE;
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    // Target and direction are frozen at the pop
    always_ff @(posedge clock) begin
        if (top_ready && top_valid && !pop_here) begin
            offer.target <= top_floor;
            offer.up     <= (top_floor > car_status.floor);
        end
    end

    // The offer may be withdrawn by a mode change but never altered
    assert property (@(posedge clock) disable iff (!reset_n)
        (dispatch_valid && !dispatch_ready) |=> (!dispatch_valid || $stable(dispatch)))
        else $error("dispatch changed while waiting for the car");

endmodule

`default_nettype wire

/* logic/floor_controller.sv */
/*
 * Elevator floor-request controller, top level.
 * Connects the mode register, request latch, request stack and
 * dispatcher. The car motion FSM sits outside on the dispatch port.
 */

`timescale 1ns/1ps
`default_nettype none

module floor_controller
    import elevator_pkg::*;
#(
    parameter int NUM_FLOORS = 11
) (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire   [NUM_FLOORS-1:0] call_buttons,
    input  wire   [NUM_FLOORS-1:0] panel_buttons,
    input  wire                    door_open_button,
    input  wire                    door_close_button,
    input  wire                    emergency,
    input  wire                    power_on,
    input  car_status_t            car_status,
    input  wire                    dispatch_ready,
    output logic                   dispatch_valid,
    output dispatch_t              dispatch,
    output logic  [NUM_FLOORS-1:0] call_lights,
    output logic  [NUM_FLOORS-1:0] panel_lights,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    mode_t  mode;
    logic   push_valid;
    logic   push_ready;
    floor_t push_floor;
    logic   top_valid;
    logic   top_ready;
    floor_t top_floor;
    logic   served_valid;
    floor_t served_floor;

    service_mode u_service_mode (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_on           (power_on),
        .emergency          (emergency),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .car_stopped        (car_status.stopped),
        .mode               (mode),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    request_latch #(.NUM_FLOORS(NUM_FLOORS)) u_request_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .mode          (mode),
        .call_buttons  (call_buttons),
        .panel_buttons (panel_buttons),
        .car_status    (car_status),
        .served_valid  (served_valid),
        .served_floor  (served_floor),
        .push_valid    (push_valid),
        .push_floor    (push_floor),
        .push_ready    (push_ready),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights)
    );

    request_stack #(.NUM_FLOORS(NUM_FLOORS)) u_request_stack (
        .clock      (clock),
        .reset_n    (reset_n),
        .mode       (mode),
        .push_valid (push_valid),
        .push_floor (push_floor),
        .push_ready (push_ready),
        .top_valid  (top_valid),
        .top_floor  (top_floor),
        .top_ready  (top_ready)
    );

    car_dispatcher u_car_dispatcher (
        .clock          (clock),
        .reset_n        (reset_n),
        .mode           (mode),
        .top_valid      (top_valid),
        .top_floor      (top_floor),
        .top_ready      (top_ready),
        .car_status     (car_status),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .served_valid   (served_valid),
        .served_floor   (served_floor)
    );

endmodule

`default_nettype wire

/* sim/floor_controller_tb.sv */
/*
 * Testbench for the elevator floor-request controller.
 * A car model answers the dispatch port, a reference model predicts lights,
 * targets and door outputs, and a compare process checks them every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module floor_controller_tb
    import elevator_pkg::*;
;

    localparam int NUM_FLOORS      = 11;
    localparam int CLK_PERIOD      = 100;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int WAIT_LIMIT      = 300;

    logic                  clock;
    logic                  reset_n;
    logic [NUM_FLOORS-1:0] call_buttons;
    logic [NUM_FLOORS-1:0] panel_buttons;
    logic                  door_open_button;
    logic                  door_close_button;
    logic                  emergency;
    logic                  power_on;
    car_status_t           car_status;
    logic                  dispatch_ready;
    logic                  dispatch_valid;
    dispatch_t             dispatch;
    logic [NUM_FLOORS-1:0] call_lights;
    logic [NUM_FLOORS-1:0] panel_lights;
    logic                  door_open_allowed;
    logic                  door_close_allowed;

    // Reference model state, as it should be after the last rising edge
    mode_t                 m_mode = MODE_OFF;
    disp_state_t           m_state = DISP_IDLE;
    logic [NUM_FLOORS-1:0] m_call = '0;
    logic [NUM_FLOORS-1:0] m_panel = '0;
    logic [NUM_FLOORS-1:0] m_queued = '0;
    floor_t                m_stack [NUM_FLOORS];
    int                    m_sp = 0;
    floor_t                m_target = '0;
    logic                  m_up = 1'b0;

    logic                  held = 1'b0;
    dispatch_t             held_dispatch;
    logic                  offer_taken = 1'b0;
    floor_t                offer_target = '0;
    logic                  hold_ready;
    floor_t                taken [$];
    int                    value_errors = 0;
    int                    other_errors = 0;
    int                    checks = 0;
    int                    door_on_seen = 0;
    int                    door_off_seen = 0;

    floor_controller #(.NUM_FLOORS(NUM_FLOORS)) uut (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_buttons       (call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency          (emergency),
        .power_on           (power_on),
        .car_status         (car_status),
        .dispatch_ready     (dispatch_ready),
        .dispatch_valid     (dispatch_valid),
        .dispatch           (dispatch),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Reference functions

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic mode_t expected_mode(input logic power, input logic emerg);
        if (!power) begin
            return MODE_OFF;
        end
        return emerg ? MODE_EMERGENCY : MODE_NORMAL;
    endfunction

    // A press lights its button unless already lit or at the floor where the car stands
    function automatic logic [NUM_FLOORS-1:0] accepted(input logic [NUM_FLOORS-1:0] buttons,
                                                       input logic [NUM_FLOORS-1:0] lights,
                                                       input logic [NUM_FLOORS-1:0] here);
        return buttons & ~lights & ~here;
    endfunction

    function automatic floor_t lowest_floor(input logic [NUM_FLOORS-1:0] mask);
        floor_t f;
        f = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                f = floor_t'(i);
            end
        end
        return f;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        value_errors++;
        $display("FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    ////////////////////
    // Compare and model update

    always @(negedge clock) begin : reference_compare
        logic [NUM_FLOORS-1:0] here;
        logic [NUM_FLOORS-1:0] served_mask;
        logic [NUM_FLOORS-1:0] pushed_mask;
        logic [NUM_FLOORS-1:0] call_acc;
        logic [NUM_FLOORS-1:0] panel_acc;
        logic                  normal;
        logic                  exp_valid;
        logic                  exp_open;
        logic                  exp_close;
        logic                  pop;
        logic                  push;
        floor_t                top;
        floor_t                pf;

        normal    = (m_mode == MODE_NORMAL);
        exp_valid = normal && (m_state == DISP_OFFER);
        exp_open  = door_open_button && car_status.stopped && (m_mode != MODE_OFF);
        exp_close = door_close_button && car_status.stopped && (m_mode != MODE_OFF);
        checks++;
        if (call_lights !== m_call) begin
            report_value("call_lights", call_lights, m_call);
        end
        if (panel_lights !== m_panel) begin
            report_value("panel_lights", panel_lights, m_panel);
        end
        if (dispatch_valid !== exp_valid) begin
            report_value("dispatch_valid", dispatch_valid, exp_valid);
        end
        if (exp_valid && dispatch.target !== m_target) begin
            report_value("dispatch.target", dispatch.target, m_target);
        end
        if (exp_valid && dispatch.up !== m_up) begin
            report_value("dispatch.up", dispatch.up, m_up);
        end
        if (held && dispatch_valid && dispatch !== held_dispatch) begin
            report_value("dispatch", dispatch, held_dispatch);
        end
        if (door_open_allowed !== exp_open) begin
            report_value("door_open_allowed", door_open_allowed, exp_open);
        end
        if (door_close_allowed !== exp_close) begin
            report_value("door_close_allowed", door_close_allowed, exp_close);
        end
        if (door_open_button && door_open_allowed) begin
            door_on_seen++;
        end
        if (door_open_button && !door_open_allowed) begin
            door_off_seen++;
        end

        held          = dispatch_valid && !dispatch_ready;
        held_dispatch = dispatch;
        offer_taken   = dispatch_valid && dispatch_ready;
        offer_target  = dispatch.target;

        // Advance the model across the coming rising edge
        for (int i = 0; i < NUM_FLOORS; i++) begin
            here[i] = car_status.stopped && (car_status.floor == floor_t'(i));
        end
        served_mask = '0;
        pushed_mask = '0;
        pop  = 1'b0;
        push = 1'b0;
        top  = '0;
        pf   = '0;
        if (!reset_n) begin
            m_mode   = MODE_OFF;
            m_state  = DISP_IDLE;
            m_call   = '0;
            m_panel  = '0;
            m_queued = '0;
            m_sp     = 0;
        end else if (!normal) begin
            m_state  = DISP_IDLE;
            m_call   = '0;
            m_panel  = '0;
            m_queued = '0;
            m_sp     = 0;
            m_mode   = expected_mode(power_on, emergency);
        end else begin
            case (m_state)
                DISP_IDLE: begin
                    if (m_sp > 0) begin
                        pop = 1'b1;
                        top = m_stack[m_sp-1];
                        if (here[top]) begin
                            served_mask[top] = 1'b1;
                        end else begin
                            m_state  = DISP_OFFER;
                            m_target = top;
                            m_up     = (top > car_status.floor);
                        end
                    end
                end
                DISP_OFFER: begin
                    if (dispatch_ready) begin
                        m_state = DISP_TRAVEL;
                    end
                end
                default: begin
                    if (car_status.stopped && car_status.floor == m_target) begin
                        served_mask[m_target] = 1'b1;
                        m_state = DISP_IDLE;
                    end
                end
            endcase
            if (m_queued != '0 && m_sp < NUM_FLOORS) begin
                push = 1'b1;
                pf   = lowest_floor(m_queued);
                pushed_mask[pf] = 1'b1;
            end
            // Push with pop takes the slot of the popped floor
            if (push && pop) begin
                m_stack[m_sp-1] = pf;
            end else if (push) begin
                m_stack[m_sp] = pf;
                m_sp++;
            end else if (pop) begin
                m_sp--;
            end
            call_acc  = accepted(call_buttons, m_call, here);
            panel_acc = accepted(panel_buttons, m_panel, here);
            m_queued  = (m_queued | ((call_acc | panel_acc) & ~(m_call | m_panel)))
                        & ~pushed_mask;
            m_call    = (m_call | call_acc) & ~served_mask;
            m_panel   = (m_panel | panel_acc) & ~served_mask;
            m_mode    = expected_mode(power_on, emergency);
        end
    end

    ////////////////////
    // Car model

    // One floor every 3 cycles, ready only while stopped and the LFSR allows it
    initial begin : car_model
        logic [31:0] lfsr;
        logic        moving;
        int          move_count;
        floor_t      car_target;

        car_status.floor   = '0;
        car_status.stopped = 1'b1;
        dispatch_ready     = 1'b0;
        lfsr       = 32'h269275e5;
        moving     = 1'b0;
        move_count = 0;
        car_target = '0;
        forever begin
            @(posedge clock);
            #5;
            if (moving) begin
                move_count++;
                if (move_count == 3) begin
                    move_count = 0;
                    if (car_target > car_status.floor) begin
                        car_status.floor = car_status.floor + 1'b1;
                    end else begin
                        car_status.floor = car_status.floor - 1'b1;
                    end
                    if (car_status.floor == car_target) begin
                        moving = 1'b0;
                        car_status.stopped = 1'b1;
                    end
                end
            end else if (offer_taken) begin
                taken.push_back(offer_target);
                car_target = offer_target;
                moving     = 1'b1;
                move_count = 0;
                car_status.stopped = 1'b0;
            end
            lfsr = lfsr_step(lfsr);
            dispatch_ready = car_status.stopped && lfsr[0] && !hold_ready;
        end
    end

    ////////////////////
    // Stimulus helpers

    task automatic drive_edge();
        @(posedge clock);
        #5;
    endtask

    task automatic press(input logic panel, input int f);
        drive_edge();
        if (panel) begin
            panel_buttons[f] = 1'b1;
        end else begin
            call_buttons[f] = 1'b1;
        end
        drive_edge();
        call_buttons  = '0;
        panel_buttons = '0;
    endtask

    task automatic wait_dispatch();
        int n;
        for (n = 0; n < WAIT_LIMIT && !dispatch_valid; n++) begin
            @(negedge clock);
        end
        if (!dispatch_valid) begin
            report_problem("timeout waiting for a dispatch offer");
        end
    endtask

    task automatic wait_stopped();
        int n;
        for (n = 0; n < WAIT_LIMIT && !car_status.stopped; n++) begin
            @(negedge clock);
        end
        if (!car_status.stopped) begin
            report_problem("timeout waiting for the car to stop");
        end
    endtask

    // All requests served and the car standing
    task automatic wait_idle();
        int   n;
        logic busy;
        busy = 1'b1;
        for (n = 0; n < WAIT_LIMIT && busy; n++) begin
            @(negedge clock);
            busy = (call_lights != '0) || (panel_lights != '0) || dispatch_valid
                   || !car_status.stopped;
        end
        if (busy) begin
            report_problem("timeout waiting for all requests to be served");
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            if (dispatch_valid !== 1'b0) begin
                report_value("dispatch_valid", dispatch_valid, 0);
            end
        end
    endtask

    task automatic check_cleared();
        if (call_lights !== '0 || panel_lights !== '0) begin
            report_value("call_lights|panel_lights", call_lights | panel_lights, 0);
        end
        if (dispatch_valid !== 1'b0) begin
            report_value("dispatch_valid", dispatch_valid, 0);
        end
    endtask

    ////////////////////
    // Test sequence

    initial begin : main
        int n;
        int base;

        reset_n           = 1'b0;
        call_buttons      = '0;
        panel_buttons     = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power_on          = 1'b1;
        hold_ready        = 1'b0;
        repeat (10) @(posedge clock);
        #5;
        reset_n = 1'b1;
        repeat (3) @(posedge clock);

        $display("Test 1: press lights its button one cycle later");
        press(1'b0, 0);
        @(negedge clock);
        if (call_lights[0] !== 1'b0) begin
            report_value("call_lights[0]", call_lights[0], 0);
        end
        press(1'b0, 3);
        @(negedge clock);
        if (call_lights[3] !== 1'b1) begin
            report_value("call_lights[3]", call_lights[3], 1);
        end
        wait_idle();

        $display("Test 2-4: stack order, held offer, lights cleared at the served floor");
        @(negedge clock);
        hold_ready = 1'b1;
        base = taken.size();
        press(1'b0, 7);
        press(1'b1, 7);
        press(1'b0, 1);
        press(1'b0, 9);
        wait_dispatch();
        repeat (12) @(negedge clock);
        hold_ready = 1'b0;
        for (n = 0; n < WAIT_LIMIT && call_lights[7]; n++) begin
            @(negedge clock);
        end
        if (call_lights[7]) begin
            report_problem("timeout waiting for floor 7 to be served");
        end
        if (panel_lights[7] !== 1'b0) begin
            report_value("panel_lights[7]", panel_lights[7], 0);
        end
        if (call_lights[1] !== 1'b1 || call_lights[9] !== 1'b1) begin
            report_value("call_lights", call_lights, 11'h202);
        end
        wait_idle();
        if (taken.size() != base + 3) begin
            report_problem("car did not accept three targets");
        end else if (taken[base] != 7 || taken[base+1] != 9 || taken[base+2] != 1) begin
            report_value("targets", {taken[base], taken[base+1], taken[base+2]}, 12'h791);
        end

        $display("Test 5: emergency and power-off clear requests");
        press(1'b0, 6);
        press(1'b1, 10);
        drive_edge();
        emergency = 1'b1;
        repeat (3) @(negedge clock);
        check_cleared();
        drive_edge();
        emergency = 1'b0;
        wait_stopped();
        expect_quiet(20);
        press(1'b0, 2);
        drive_edge();
        power_on = 1'b0;
        repeat (3) @(negedge clock);
        check_cleared();
        drive_edge();
        power_on = 1'b1;
        wait_stopped();
        expect_quiet(20);
        press(1'b0, 4);
        wait_dispatch();
        wait_idle();

        $display("Test 6: door requests gated by stop and power");
        drive_edge();
        door_open_button = 1'b1;
        repeat (3) @(negedge clock);
        press(1'b0, 0);
        wait_idle();
        drive_edge();
        door_close_button = 1'b1;
        power_on          = 1'b0;
        repeat (3) @(negedge clock);
        drive_edge();
        power_on          = 1'b1;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        repeat (3) @(negedge clock);
        if (door_on_seen == 0 || door_off_seen == 0) begin
            report_problem("door request was never both granted and refused");
        end

        $display("Checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clock);
        $display("Watchdog expired after %0d cycles, value errors %0d, other errors %0d",
                 NUM_TESTS * CYCLES_PER_TEST, value_errors, other_errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/elevator_pkg.sv
logic/service_mode.sv
logic/request_latch.sv
logic/request_stack.sv
logic/car_dispatcher.sv
logic/floor_controller.sv
sim/floor_controller_tb.sv

/* Makefile */
TOP = floor_controller_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "Everything OK" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
